// ==== filelist.f ====
+incdir+source
source/base_pkg.sv
source/score_pkg.sv
source/seq_loader.sv
source/target_feeder.sv
source/sw_cell.sv
source/sw_array.sv
source/score_collector.sv
source/sw_aligner_top.sv
tb/tb_sw_aligner.sv

// ==== tb/tb_sw_aligner.sv ====
//////////////////////////////////////////////////////////////////////
// Testbench for the Smith-Waterman aligner
// Table of query/target pairs with hand-scored results, run in a loop
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sw_consts.svh"

module tb_sw_aligner;
  import base_pkg::*;

  localparam int NUM_ROWS     = 9;
  localparam int RESET_CYCLES = 4;
  localparam int IDLE_CYCLES  = 3;                             // Quiet cycles checked after reset
  localparam int CYCLE_LIMIT  = 40 * NUM_ROWS + RESET_CYCLES + IDLE_CYCLES;

  typedef struct packed {
    logic [63:0] query_txt;                                    // ASCII bases, first char = base 0
    logic [15:0] query_len;                                    // Length field as sent
    logic [63:0] target_txt;
    logic [15:0] target_len;
    logic        little_endian;
    logic        extra_beat;                                   // Strobe a stray beat while busy
    logic [15:0] expected;                                     // Hand-scored, host byte order
  } test_row_t;

  logic                 ha_pclock;
  logic                 reset;
  logic                 seq_valid;
  seq_beat_t            seq_beat;
  logic                 little_endian;
  logic                 busy;
  logic                 result_valid;
  logic [`RESULT_W-1:0] result;

  test_row_t rows [NUM_ROWS];
  int        row_count    = 0;
  int        error_count  = 0;
  int        tests_failed = 0;
  int        cycle_count  = 0;

  sw_aligner_top i_sw_aligner_top (
    .ha_pclock(ha_pclock), .reset(reset), .seq_valid(seq_valid), .seq_beat(seq_beat),
    .little_endian(little_endian), .busy(busy), .result_valid(result_valid), .result(result)
  );

  initial
  begin
    ha_pclock = 1'b0;
    forever #5 ha_pclock = ~ha_pclock;                         // 10 ns period
  end

  always @(posedge ha_pclock)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT)
    begin
      $display("Timeout: no result after %0d cycles, the DUT stopped responding", cycle_count);
      $display("Errors found");
      $finish;
    end
  end

  function automatic logic [15:0] byte_swap16(input logic [15:0] value, input logic le);
    return le ? {value[7:0], value[15:8]} : value;
  endfunction

  // A=0 C=1 G=2 T=3, unused positions stay A
  function automatic base_vec_t text_to_bases(input logic [63:0] txt);
    base_vec_t  vec;
    int         nchars;
    logic [7:0] ch;
    vec    = '0;
    nchars = 0;
    for (int b = 0; b < 8; b++)
      if (txt[8*b +: 8] != 8'h00) nchars = b + 1;              // Literal is right-justified
    for (int k = 0; k < nchars; k++)
    begin
      ch = txt[8*(nchars-1-k) +: 8];
      case (ch)
        "C":     vec[2*k +: 2] = 2'd1;
        "G":     vec[2*k +: 2] = 2'd2;
        "T":     vec[2*k +: 2] = 2'd3;
        default: vec[2*k +: 2] = 2'd0;
      endcase
    end
    return vec;
  endfunction

  function automatic seq_beat_t make_beat(input logic [15:0] len, input base_vec_t bases,
                                          input logic le);
    seq_beat_t beat;
    beat.len   = byte_swap16(len, le);                         // Bytes go out swapped on LE
    beat.bases = byte_swap16(bases, le);
    return beat;
  endfunction

  task automatic add_row(input logic [63:0] q_txt, input int q_len, input logic [63:0] t_txt,
                         input int t_len, input logic le, input logic extra,
                         input logic [15:0] expected);
    test_row_t row;
    row.query_txt     = q_txt;
    row.query_len     = 16'(q_len);
    row.target_txt    = t_txt;
    row.target_len    = 16'(t_len);
    row.little_endian = le;
    row.extra_beat    = extra;
    row.expected      = expected;
    rows[row_count]   = row;
    row_count++;
  endtask

  // Match +5, mismatch -4, gap 12 then 4 per base, floor 0
  task automatic load_table();
    add_row("ACGTACGT", 8, "ACGTACGT", 8, 0, 0, 16'd40);       // Identical, 8 matches
    add_row("GATC", 4, "TTGATCAA", 8, 0, 0, 16'd20);           // Short query inside target
    add_row("AAAAAAAA", 8, "TTTTTTTT", 8, 0, 0, 16'd0);        // Nothing matches
    add_row("ACGTACGT", 8, 64'h0, 0, 0, 0, 16'd0);             // Empty target
    add_row("ACGTACGT", 8, "ACGACGT", 7, 0, 0, 16'd23);        // 7 matches, one gap open
    add_row("TTAC", 4, "GTTACA", 6, 1, 0, 16'd20);             // Little endian
    add_row("GGCCA", 5, "GGCCA", 5, 0, 1, 16'd25);             // Stray beat while busy
    add_row("CATGCATG", 12, "CATG", 4, 1, 0, 16'd20);          // Length 12 clipped to 8
    add_row("GGGGGACG", 8, "ACGTT", 5, 0, 0, 16'd15);          // Best on last cell, mid-target
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    assert (actual === expected)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic run_row(input int idx);
    test_row_t   row;
    int          errors_before;
    logic [15:0] expected;
    row           = rows[idx];
    errors_before = error_count;
    expected      = byte_swap16(row.expected, row.little_endian);
    @(posedge ha_pclock);
    seq_valid     <= 1'b1;                                     // Query beat
    seq_beat      <= make_beat(row.query_len, text_to_bases(row.query_txt), row.little_endian);
    little_endian <= row.little_endian;
    @(posedge ha_pclock);
    seq_beat <= make_beat(row.target_len, text_to_bases(row.target_txt), row.little_endian);
    @(posedge ha_pclock);
    seq_valid <= 1'b0;                                         // Target taken on this edge
    @(posedge ha_pclock);
    @(negedge ha_pclock);
    check_value("busy", 16'd1, {15'd0, busy});                 // One edge after target
    if (row.extra_beat)
    begin
      @(posedge ha_pclock);
      seq_valid <= 1'b1;
      seq_beat  <= make_beat(16'd8, text_to_bases("TTTTTTTT"), row.little_endian);
      @(posedge ha_pclock);
      seq_valid <= 1'b0;
    end
    @(negedge ha_pclock);
    while (result_valid !== 1'b1)
      @(negedge ha_pclock);                                    // Bounded by the cycle counter
    check_value("result", expected, result);
    check_value("busy", 16'd0, {15'd0, busy});                 // Drops with result_valid
    if (error_count != errors_before)
      tests_failed++;
    $display("Test %0d %s: result %h, expected %h", idx,
             (error_count == errors_before) ? "passed" : "FAILED", result, expected);
  endtask

  initial
  begin
    reset         = 1'b1;
    seq_valid     = 1'b0;
    seq_beat      = '0;
    little_endian = 1'b0;
    load_table();
    repeat (RESET_CYCLES) @(posedge ha_pclock);
    reset <= 1'b0;
    repeat (IDLE_CYCLES)
    begin
      @(negedge ha_pclock);
      check_value("busy", 16'd0, {15'd0, busy});
      check_value("result_valid", 16'd0, {15'd0, result_valid});
    end
    if (error_count != 0)
      tests_failed++;
    $display("Test idle after reset %s", (error_count == 0) ? "passed" : "FAILED");
    for (int i = 0; i < NUM_ROWS; i++)
      run_row(i);
    $display("Summary: %0d tests, %0d failed, %0d failed checks",
             NUM_ROWS + 1, tests_failed, error_count);
    if (error_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== source/sw_aligner_top.sv ====
//////////////////////////////////////////////////////////////////////
// Smith-Waterman aligner top
// Loader, feeder, systolic array and collector in a pipeline
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sw_consts.svh"

module sw_aligner_top (
  input  logic                 ha_pclock,
  input  logic                 reset,
  input  logic                 seq_valid,
  input  base_pkg::seq_beat_t  seq_beat,
  input  logic                 little_endian,
  output logic                 busy,
  output logic                 result_valid,
  output logic [`RESULT_W-1:0] result
);
  import base_pkg::*;
  import score_pkg::*;

  logic       start;
  logic       done;
  base_vec_t  query;
  seq_len_t   query_len;
  base_vec_t  target;
  seq_len_t   target_len;
  base_flow_t target_flow;                                     // Feeder into array
  cell_flow_t array_flow;                                      // Array end

  seq_loader i_seq_loader (
    .ha_pclock(ha_pclock), .reset(reset), .seq_valid(seq_valid), .seq_beat(seq_beat),
    .little_endian(little_endian), .done(done), .busy(busy), .start(start),
    .query(query), .query_len(query_len), .target(target), .target_len(target_len)
  );

  target_feeder i_target_feeder (
    .ha_pclock(ha_pclock), .reset(reset), .start(start), .target(target),
    .target_len(target_len), .flow(target_flow)
  );

  sw_array i_sw_array (
    .ha_pclock(ha_pclock), .reset(reset), .query(query), .query_len(query_len),
    .flow(target_flow), .flow_out(array_flow)
  );

  score_collector i_score_collector (
    .ha_pclock(ha_pclock), .reset(reset), .flow(array_flow), .little_endian(little_endian),
    .done(done), .result_valid(result_valid), .result(result)
  );

endmodule

// ==== source/score_collector.sv ====
//////////////////////////////////////////////////////////////////////
// Score collector
// Catches the last column at the array end and formats the result
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sw_consts.svh"

module score_collector (
  input  logic                  ha_pclock,
  input  logic                  reset,
  input  score_pkg::cell_flow_t flow,
  input  logic                  little_endian,
  output logic                  done,
  output logic                  result_valid,
  output logic [`RESULT_W-1:0]  result
);
  import base_pkg::*;
  import score_pkg::*;

  collect_state_t       state;
  score_t               best_run;                              // Best of columns already out
  logic [`RESULT_W-1:0] best_wide;                             // Zero-extended best

  // Last cell's H of earlier columns only shows up here
  assign best_wide    = {{(`RESULT_W - `SCORE_W){1'b0}}, score_max(best_run, flow.best)};
  assign done         = (state == WAIT) && flow.bflow.last;    // Frees the loader
  assign result_valid = (state == DONE);

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
      state <= WAIT;
    else
    begin
      case (state)
        WAIT:    if (done) state <= DONE;
        DONE:    state <= WAIT;                                // One-cycle result pulse
        default: state <= WAIT;
      endcase
    end
  end

  always_ff @(posedge ha_pclock)
  begin
    if (reset || done)
      best_run <= '0;                                          // Fresh job
    else if (flow.bflow.valid)
      best_run <= score_max(best_run, flow.best);
  end

  always_ff @(posedge ha_pclock)
  begin
    if (done) result <= swap_bytes(best_wide, little_endian);  // Same byte order as beats
  end

endmodule

// ==== source/sw_array.sv ====
//////////////////////////////////////////////////////////////////////
// Systolic scoring array
// One cell per query base, running best merged between cells
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sw_consts.svh"

module sw_array (
  input  logic                  ha_pclock,
  input  logic                  reset,
  input  base_pkg::base_vec_t   query,
  input  base_pkg::seq_len_t    query_len,
  input  base_pkg::base_flow_t  flow,
  output score_pkg::cell_flow_t flow_out
);
  import base_pkg::*;
  import score_pkg::*;

  cell_flow_t              link [`QUERY_BASES+1];              // Index 0 feeds cell 0
  cell_flow_t              cell_out [`QUERY_BASES];
  logic [`QUERY_BASES-1:0] cell_en;                            // Cell lies inside the query

  // Fold a cell's H into the running best when the cell counts
  function automatic cell_flow_t merge_best(input cell_flow_t c, input logic en);
    cell_flow_t m;
    m = c;
    if (en && c.bflow.valid) m.best = score_max(c.best, c.h);
    return m;
  endfunction

  assign link[0]  = '{bflow: flow, h: '0, f: '0, best: '0};    // Top row boundary
  assign flow_out = link[`QUERY_BASES];

  for (genvar i = 0; i < `QUERY_BASES; i++)
  begin : g_cell
    assign cell_en[i] = (seq_len_t'(i) < query_len);
    sw_cell i_sw_cell (
      .ha_pclock  (ha_pclock),
      .reset      (reset),
      .query_base (base_t'(query[i*`BASE_W +: `BASE_W])),
      .flow_in    (link[i]),
      .flow_out   (cell_out[i])
    );
    assign link[i+1] = merge_best(cell_out[i], cell_en[i]);
  end

endmodule

// ==== source/sw_cell.sv ====
//////////////////////////////////////////////////////////////////////
// Systolic Smith-Waterman cell
// Holds one query base, scores each passing target base with affine gaps
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sw_consts.svh"

module sw_cell (
  input  logic                  ha_pclock,
  input  logic                  reset,
  input  base_pkg::base_t       query_base,
  input  score_pkg::cell_flow_t flow_in,
  output score_pkg::cell_flow_t flow_out
);
  import score_pkg::*;

  score_t h_row;                                               // Own H, previous column
  score_t e_row;                                               // Horizontal gap, previous column
  score_t diag_h;                                              // Upstream H, previous column
  score_t best_hold;                                           // Best passed on so far
  score_t diag_score;
  score_t e_new;
  score_t f_new;
  score_t h_new;
  score_t best_new;

  always_comb
  begin
    if (flow_in.bflow.base == query_base)
      diag_score = diag_h + score_t'(`MATCH_SCORE);
    else
      diag_score = score_sub(diag_h, score_t'(`MISMATCH_PENALTY));
    // Gap opened from H, or an open gap extended
    e_new = score_max(score_sub(h_row, score_t'(`GAP_OPEN_PENALTY)),
                      score_sub(e_row, score_t'(`GAP_EXTEND_PENALTY)));
    f_new = score_max(score_sub(flow_in.h, score_t'(`GAP_OPEN_PENALTY)),
                      score_sub(flow_in.f, score_t'(`GAP_EXTEND_PENALTY)));
    h_new    = score_max(diag_score, score_max(e_new, f_new)); // Floor 0 by type
    best_new = score_max(flow_in.best, best_hold);
  end

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      flow_out  <= '0;
      h_row     <= '0;
      e_row     <= '0;
      diag_h    <= '0;
      best_hold <= '0;
    end
    else
    begin
      flow_out.bflow <= flow_in.bflow;                         // Base moves on one cell
      flow_out.h     <= flow_in.bflow.valid ? h_new : '0;
      flow_out.f     <= flow_in.bflow.valid ? f_new : '0;
      flow_out.best  <= flow_in.bflow.valid ? best_new : flow_in.best;
      if (flow_in.bflow.valid)
      begin
        h_row     <= h_new;
        e_row     <= e_new;
        diag_h    <= flow_in.h;                                // Diagonal for next column
        best_hold <= best_new;
      end
      if (flow_in.bflow.last)
      begin
        h_row     <= '0;                                       // Fresh row for next job
        e_row     <= '0;
        diag_h    <= '0;
        best_hold <= '0;
      end
    end
  end

endmodule

// ==== source/target_feeder.sv ====
//////////////////////////////////////////////////////////////////////
// Target feeder
// Shifts target bases into the cell chain, one per cycle
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sw_consts.svh"

module target_feeder (
  input  logic                 ha_pclock,
  input  logic                 reset,
  input  logic                 start,
  input  base_pkg::base_vec_t  target,
  input  base_pkg::seq_len_t   target_len,
  output base_pkg::base_flow_t flow
);
  import base_pkg::*;

  base_vec_t shreg;                                            // Bases not yet sent
  seq_len_t  count;                                            // Bases sent so far
  seq_len_t  last_idx;
  logic      active;

  assign last_idx = target_len - seq_len_t'(1);

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      flow   <= '0;
      active <= 1'b0;
      count  <= '0;
    end
    else if (start)
    begin
      // First base leaves right away, zero length sends a bare last
      flow   <= '{valid: (target_len != '0),
                  base:  base_t'(target[`BASE_W-1:0]),
                  last:  (target_len <= seq_len_t'(1))};
      active <= (target_len > seq_len_t'(1));
      count  <= seq_len_t'(1);
    end
    else if (active)
    begin
      flow   <= '{valid: 1'b1,
                  base:  base_t'(shreg[`BASE_W-1:0]),
                  last:  (count == last_idx)};
      active <= (count != last_idx);                           // Stop after final base
      count  <= count + seq_len_t'(1);
    end
    else
    begin
      flow <= '0;                                              // Idle bubble
    end
  end

  always_ff @(posedge ha_pclock)
  begin
    if (start) shreg <= target >> `BASE_W;
    else if (active) shreg <= shreg >> `BASE_W;
  end

endmodule

// ==== source/seq_loader.sv ====
//////////////////////////////////////////////////////////////////////
// Sequence loader
// Takes the query beat then the target beat, fixes byte order,
// clips lengths and starts the feeder once the target is held
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`include "sw_consts.svh"

module seq_loader (
  input  logic                 ha_pclock,
  input  logic                 reset,
  input  logic                 seq_valid,
  input  base_pkg::seq_beat_t  seq_beat,
  input  logic                 little_endian,
  input  logic                 done,
  output logic                 busy,
  output logic                 start,
  output base_pkg::base_vec_t  query,
  output base_pkg::seq_len_t   query_len,
  output base_pkg::base_vec_t  target,
  output base_pkg::seq_len_t   target_len
);
  import base_pkg::*;

  load_state_t state;
  seq_len_t    beat_len;                                       // Length after byte fix
  base_vec_t   beat_bases;                                     // Bases after byte fix
  seq_len_t    beat_len_clip;

  assign beat_len      = swap_bytes(seq_beat.len, little_endian);
  assign beat_bases    = swap_bytes(seq_beat.bases, little_endian);
  assign beat_len_clip = (beat_len > seq_len_t'(`QUERY_BASES)) ? seq_len_t'(`QUERY_BASES)
                                                               : beat_len;
  assign busy = (state == BUSY);                               // Beats ignored while high

  always_ff @(posedge ha_pclock)
  begin
    if (reset)
    begin
      state <= IDLE;
      start <= 1'b0;
    end
    else
    begin
      start <= 1'b0;                                           // Single-cycle pulse
      case (state)
        IDLE:        if (seq_valid) state <= LOAD_TARGET;      // Query beat taken
        LOAD_TARGET:
          if (start) state <= BUSY;                            // Busy one edge after target
          else if (seq_valid) start <= 1'b1;
        BUSY:        if (done) state <= IDLE;
        default:     state <= IDLE;
      endcase
    end
  end

  // Sequence holding registers, stable for the whole job
  always_ff @(posedge ha_pclock)
  begin
    if (seq_valid && (state == IDLE))
    begin
      query     <= beat_bases;
      query_len <= beat_len_clip;
    end
    if (seq_valid && (state == LOAD_TARGET) && !start)
    begin
      target     <= beat_bases;
      target_len <= beat_len_clip;
    end
  end

endmodule

// ==== source/score_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Scoring types for the alignment scorer
// Score values, the cell-to-cell flow and the collector FSM
//////////////////////////////////////////////////////////////////////
`include "sw_consts.svh"

package score_pkg;

  typedef logic [`SCORE_W-1:0] score_t;                        // Unsigned, floors at 0

  typedef struct packed {
    base_pkg::base_flow_t bflow;                               // Target base riding along
    score_t               h;                                   // H of this column
    score_t               f;                                   // Vertical gap score
    score_t               best;                                // Running best so far
  } cell_flow_t;

  typedef enum logic {WAIT, DONE} collect_state_t;

  // Subtract with floor at zero
  function automatic score_t score_sub(input score_t a, input score_t b);
    return (a > b) ? a - b : '0;
  endfunction

  function automatic score_t score_max(input score_t a, input score_t b);
    return (a > b) ? a : b;
  endfunction

endpackage

// ==== source/base_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Sequence types for the alignment scorer
// Bases, lengths, input beats and the streamed target base
//////////////////////////////////////////////////////////////////////
`include "sw_consts.svh"

package base_pkg;

  typedef enum logic [`BASE_W-1:0] {A = 2'd0, C = 2'd1, G = 2'd2, T = 2'd3} base_t;

  typedef logic [`LEN_W-1:0] seq_len_t;                        // Length in bases
  typedef logic [`QUERY_BASES*`BASE_W-1:0] base_vec_t;          // Base 0 in low bits

  typedef struct packed {
    seq_len_t  len;                                            // Upper half of the beat
    base_vec_t bases;
  } seq_beat_t;

  typedef struct packed {
    logic  valid;                                              // Base present this cycle
    base_t base;
    logic  last;                                               // Final column of the job
  } base_flow_t;

  typedef enum logic [1:0] {IDLE, LOAD_TARGET, BUSY} load_state_t;

  // Byte swap for the 16-bit beat fields and the result
  function automatic logic [`LEN_W-1:0] swap_bytes(input logic [`LEN_W-1:0] value,
                                                   input logic swap);
    return swap ? {value[7:0], value[15:8]} : value;
  endfunction

endpackage

// ==== source/sw_consts.svh ====
//////////////////////////////////////////////////////////////////////
// Alignment scorer constants
// Array size, field widths and affine-gap scoring penalties
//////////////////////////////////////////////////////////////////////
`ifndef SW_CONSTS_SVH
`define SW_CONSTS_SVH

// Sizes
`define QUERY_BASES 8          // Cells in the chain, also max sequence length
`define BASE_W 2               // One DNA base
`define LEN_W 16               // Length field of a beat
`define SCORE_W 12             // Internal score, never negative
`define RESULT_W 16            // Result field on the output

// Scoring, all applied as positive magnitudes
`define MATCH_SCORE 5          // Added on equal bases
`define MISMATCH_PENALTY 4     // Subtracted on unequal bases
`define GAP_OPEN_PENALTY 12    // First gapped base
`define GAP_EXTEND_PENALTY 4   // Each further gapped base

`endif
